// File: source/mtrPkg.sv
package mtrPkg;

  localparam int countWidth = 17;
  localparam int periodWidth = 12;

  // Bit positions inside mtrCmd.clrMask
  localparam int clrTime = 0;
  localparam int clrPerf = 1;
  localparam int clrEbox = 2;
  localparam int clrCache = 3;
  localparam int clrInterval = 4;

  typedef enum logic [2:0] {
    opNone,
    opCtlMtr,
    opCtlTim,
    opClear,
    opLoadPa
  } mtrOp;

  typedef enum logic [2:0] {
    regTime,
    regPerf,
    regEbox,
    regCache,
    regInterval,
    regStatus,
    regNone
  } mtrReg;

  typedef struct packed {
    logic acctOn;
    logic piAcctEn;
    logic execAcctEn;
    logic timeOn;
  } mtrCtl;

  typedef struct packed {
    logic                   intervalOn;
    logic [periodWidth-1:0] period;
  } tmrCtl;

  typedef struct packed {
    logic userOnly;
    logic eventMode;
  } paCtl;

  typedef struct packed {
    mtrOp       op;
    logic [4:0] clrMask;
    logic       clrFlags;
  } mtrCmd;

  typedef struct packed {
    logic userMode;
    logic piActive;
    logic mboxXfer;
    logic eboxWait;
  } cpuState;

  typedef struct packed {
    logic [countWidth-1:0]  timeCount;
    logic [countWidth-1:0]  perfCount;
    logic [countWidth-1:0]  eboxCount;
    logic [countWidth-1:0]  cacheCount;
    logic [periodWidth-1:0] intervalCount;
  } mtrCounts;

  typedef struct packed {
    logic done;
    logic overflow;
  } tmrFlags;

endpackage

// File: source/mtrAxiSlave.sv
`timescale 1ns/1ps

module mtrAxiSlave (
  input  logic          MBOX_CLK,
  input  logic          RESET,
  input  logic [7:0]    awaddr,
  input  logic          awvalid,
  output logic          awready,
  input  logic [31:0]   wdata,
  input  logic [3:0]    wstrb,
  input  logic          wvalid,
  output logic          wready,
  output logic [1:0]    bresp,
  output logic          bvalid,
  input  logic          bready,
  input  logic [7:0]    araddr,
  input  logic          arvalid,
  output logic          arready,
  output logic [31:0]   rdata,
  output logic [1:0]    rresp,
  output logic          rvalid,
  input  logic          rready,
  output mtrPkg::mtrCtl mtrCtl,
  output mtrPkg::tmrCtl tmrCtl,
  output mtrPkg::paCtl  paCtl,
  output mtrPkg::mtrCmd cmd,
  output mtrPkg::mtrReg readSel,
  input  logic [31:0]   readData
);
  import mtrPkg::*;

  mtrOp        wrOp;
  logic [31:0] curWord;
  logic [31:0] wrWord;
  logic        wrAccept;
  logic        arAccept;
  logic        rdPending;

  function automatic mtrOp decodeWrite(input logic [7:0] addr);
    case (addr)
      8'h00:   decodeWrite = opCtlMtr;
      8'h04:   decodeWrite = opCtlTim;
      8'h08:   decodeWrite = opClear;
      8'h0C:   decodeWrite = opLoadPa;
      default: decodeWrite = opNone;
    endcase
  endfunction

  function automatic mtrReg decodeRead(input logic [7:0] addr);
    case (addr)
      8'h10:   decodeRead = regTime;
      8'h14:   decodeRead = regPerf;
      8'h18:   decodeRead = regEbox;
      8'h1C:   decodeRead = regCache;
      8'h20:   decodeRead = regInterval;
      8'h24:   decodeRead = regStatus;
      default: decodeRead = regNone;
    endcase
  endfunction

  assign wrOp = decodeWrite(awaddr);
  assign wrAccept = awready & awvalid & wvalid;
  assign bresp = 2'b00;
  assign rresp = 2'b00;

  // Byte lanes not strobed keep the register's present contents
  always_comb begin
    case (wrOp)
      opCtlMtr: curWord = {28'b0, mtrCtl};
      opCtlTim: curWord = {19'b0, tmrCtl};
      opLoadPa: curWord = {30'b0, paCtl};
      default:  curWord = '0;
    endcase
    for (int i = 0; i < 4; i++) begin
      wrWord[8*i +: 8] = wstrb[i] ? wdata[8*i +: 8] : curWord[8*i +: 8];
    end
  end

  always_ff @(posedge MBOX_CLK or posedge RESET) begin
    if (RESET) begin
      awready <= 1'b0;
      wready <= 1'b0;
      bvalid <= 1'b0;
      mtrCtl <= '0;
      tmrCtl <= '0;
      paCtl <= '0;
      cmd.op <= opNone;
      cmd.clrMask <= '0;
      cmd.clrFlags <= 1'b0;
    end else begin
      cmd.op <= opNone;
      cmd.clrMask <= '0;
      cmd.clrFlags <= 1'b0;
      if (wrAccept) begin
        awready <= 1'b0;
        wready <= 1'b0;
        bvalid <= 1'b1;
        case (wrOp)
          opCtlMtr: begin
            mtrCtl <= wrWord[3:0];
            cmd.op <= opCtlMtr;
          end
          opCtlTim: begin
            tmrCtl <= wrWord[12:0];
            cmd.op <= opCtlTim;
            cmd.clrMask[clrInterval] <= wrWord[13];
          end
          opClear: begin
            cmd.op <= opClear;
            cmd.clrMask <= wrWord[4:0];
            cmd.clrFlags <= wrWord[5];
          end
          opLoadPa: begin
            paCtl <= wrWord[1:0];
            cmd.op <= opLoadPa;
          end
          default: begin
          end
        endcase
      end else begin
        // Ready goes high for one cycle once both channels are valid
        awready <= awvalid & wvalid & ~bvalid & ~awready;
        wready <= awvalid & wvalid & ~bvalid & ~awready;
        if (bvalid && bready) begin
          bvalid <= 1'b0;
        end
      end
    end
  end

  assign arready = ~rdPending & ~rvalid;
  assign arAccept = arvalid & arready;

  always_ff @(posedge MBOX_CLK or posedge RESET) begin
    if (RESET) begin
      rdPending <= 1'b0;
      rvalid <= 1'b0;
      readSel <= regNone;
    end else begin
      if (arAccept) begin
        readSel <= decodeRead(araddr);
        rdPending <= 1'b1;
      end
      if (rdPending) begin
        rvalid <= 1'b1;
        rdPending <= 1'b0;
      end else if (rvalid && rready) begin
        rvalid <= 1'b0;
      end
    end
  end

  // Snapshot of the selected register, held while RVALID waits
  always_ff @(posedge MBOX_CLK) begin
    if (rdPending) begin
      rdata <= readData;
    end
  end

endmodule

// File: source/mtrTimeBase.sv
`timescale 1ns/1ps

module mtrTimeBase #(
  parameter int tickDivisor = 33
) (
  input  logic                           MBOX_CLK,
  input  logic                           RESET,
  input  mtrPkg::mtrCtl                  mtrCtl,
  input  mtrPkg::tmrCtl                  tmrCtl,
  input  mtrPkg::mtrCmd                  cmd,
  output logic [mtrPkg::countWidth-1:0]  timeCount,
  output logic [mtrPkg::periodWidth-1:0] intervalCount,
  output mtrPkg::tmrFlags                flags,
  output logic                           irq
);
  import mtrPkg::*;

  localparam int preWidth = (tickDivisor > 1) ? $clog2(tickDivisor) : 1;

  logic [preWidth-1:0]    preCount;
  logic                   tick;
  logic                   clrTimeCmd;
  logic                   clrIntCmd;
  logic                   clrFlagCmd;
  logic [periodWidth-1:0] nextInterval;
  logic                   intervalWrap;

  // One tick per microsecond
  assign tick = (preCount == preWidth'(tickDivisor - 1));

  always_ff @(posedge MBOX_CLK or posedge RESET) begin
    if (RESET) begin
      preCount <= '0;
    end else if (tick) begin
      preCount <= '0;
    end else begin
      preCount <= preCount + 1'b1;
    end
  end

  assign clrTimeCmd = (cmd.op == opClear) && cmd.clrMask[clrTime];
  // Interval counter is also reset from the timer control write
  assign clrIntCmd = (cmd.op inside {opClear, opCtlTim}) && cmd.clrMask[clrInterval];
  assign clrFlagCmd = (cmd.op == opClear) && cmd.clrFlags;

  always_ff @(posedge MBOX_CLK or posedge RESET) begin
    if (RESET) begin
      timeCount <= '0;
    end else if (clrTimeCmd) begin
      timeCount <= '0;
    end else if (tick && mtrCtl.timeOn) begin
      timeCount <= timeCount + 1'b1;
    end
  end

  assign nextInterval = intervalCount + 1'b1;
  assign intervalWrap = tick && tmrCtl.intervalOn && !clrIntCmd &&
                        (nextInterval == tmrCtl.period);

  always_ff @(posedge MBOX_CLK or posedge RESET) begin
    if (RESET) begin
      intervalCount <= '0;
    end else if (clrIntCmd || intervalWrap) begin
      intervalCount <= '0;
    end else if (tick && tmrCtl.intervalOn) begin
      intervalCount <= nextInterval;
    end
  end

  // A period end while done is still set counts as an overrun
  always_ff @(posedge MBOX_CLK or posedge RESET) begin
    if (RESET) begin
      flags.done <= 1'b0;
      flags.overflow <= 1'b0;
    end else if (clrFlagCmd) begin
      flags.done <= 1'b0;
      flags.overflow <= 1'b0;
    end else if (intervalWrap) begin
      flags.done <= 1'b1;
      if (flags.done) begin
        flags.overflow <= 1'b1;
      end
    end
  end

  assign irq = flags.done;

endmodule

// File: source/mtrAccounting.sv
`timescale 1ns/1ps

module mtrAccounting (
  input  logic                          MBOX_CLK,
  input  logic                          RESET,
  input  mtrPkg::mtrCtl                 mtrCtl,
  input  mtrPkg::paCtl                  paCtl,
  input  mtrPkg::mtrCmd                 cmd,
  input  mtrPkg::cpuState               cpu,
  output logic [mtrPkg::countWidth-1:0] perfCount,
  output logic [mtrPkg::countWidth-1:0] eboxCount,
  output logic [mtrPkg::countWidth-1:0] cacheCount
);
  import mtrPkg::*;

  cpuState cpuQ;
  logic    clearCmd;
  logic    acctEn;
  logic    perfEvent;
  logic    perfEn;

  always_ff @(posedge MBOX_CLK or posedge RESET) begin
    if (RESET) begin
      cpuQ <= '0;
    end else begin
      cpuQ <= cpu;
    end
  end

  assign clearCmd = (cmd.op == opClear);

  // Interrupt and exec time only when software asked for them
  assign acctEn = mtrCtl.acctOn &&
                  (!cpuQ.piActive || mtrCtl.piAcctEn) &&
                  (cpuQ.userMode || mtrCtl.execAcctEn);

  // Event mode counts transfers, otherwise wait cycles
  assign perfEvent = paCtl.eventMode ? cpuQ.mboxXfer : cpuQ.eboxWait;
  assign perfEn = perfEvent && (cpuQ.userMode || !paCtl.userOnly);

  always_ff @(posedge MBOX_CLK or posedge RESET) begin
    if (RESET) begin
      perfCount <= '0;
      eboxCount <= '0;
      cacheCount <= '0;
    end else begin
      if (clearCmd && cmd.clrMask[clrPerf]) begin
        perfCount <= '0;
      end else if (perfEn) begin
        perfCount <= perfCount + 1'b1;
      end
      if (clearCmd && cmd.clrMask[clrEbox]) begin
        eboxCount <= '0;
      end else if (acctEn && !cpuQ.eboxWait) begin
        eboxCount <= eboxCount + 1'b1;
      end
      if (clearCmd && cmd.clrMask[clrCache]) begin
        cacheCount <= '0;
      end else if (acctEn && cpuQ.mboxXfer) begin
        cacheCount <= cacheCount + 1'b1;
      end
    end
  end

endmodule

// File: source/mtrReadback.sv
`timescale 1ns/1ps

module mtrReadback (
  input  mtrPkg::mtrReg    readSel,
  input  mtrPkg::mtrCounts counts,
  input  mtrPkg::tmrFlags  flags,
  input  mtrPkg::mtrCtl    mtrCtl,
  input  mtrPkg::tmrCtl    tmrCtl,
  output logic [31:0]      readData
);
  import mtrPkg::*;

  logic [31:0] statusWord;

  // Period in 11:0, then intervalOn, done, overflow, mtrCtl in 18:15
  assign statusWord = {13'b0, mtrCtl, flags.overflow, flags.done,
                       tmrCtl.intervalOn, tmrCtl.period};

  always_comb begin
    case (readSel)
      regTime:     readData = 32'(counts.timeCount);
      regPerf:     readData = 32'(counts.perfCount);
      regEbox:     readData = 32'(counts.eboxCount);
      regCache:    readData = 32'(counts.cacheCount);
      regInterval: readData = 32'(counts.intervalCount);
      regStatus:   readData = statusWord;
      regNone:     readData = '0;
      default:     readData = '0;
    endcase
  end

endmodule

// File: source/mtrTop.sv
`timescale 1ns/1ps

module mtrTop #(
  parameter int tickDivisor = 33
) (
  input  logic            MBOX_CLK,
  input  logic            RESET,
  input  logic [7:0]      awaddr,
  input  logic            awvalid,
  output logic            awready,
  input  logic [31:0]     wdata,
  input  logic [3:0]      wstrb,
  input  logic            wvalid,
  output logic            wready,
  output logic [1:0]      bresp,
  output logic            bvalid,
  input  logic            bready,
  input  logic [7:0]      araddr,
  input  logic            arvalid,
  output logic            arready,
  output logic [31:0]     rdata,
  output logic [1:0]      rresp,
  output logic            rvalid,
  input  logic            rready,
  input  mtrPkg::cpuState cpu,
  output logic            irq
);
  import mtrPkg::*;

  mtrCtl                  mtrCtlQ;
  tmrCtl                  tmrCtlQ;
  paCtl                   paCtlQ;
  mtrCmd                  cmd;
  mtrReg                  readSel;
  logic [31:0]            readData;
  mtrCounts               counts;
  tmrFlags                flags;
  logic [countWidth-1:0]  timeCount;
  logic [countWidth-1:0]  perfCount;
  logic [countWidth-1:0]  eboxCount;
  logic [countWidth-1:0]  cacheCount;
  logic [periodWidth-1:0] intervalCount;

  assign counts.timeCount = timeCount;
  assign counts.perfCount = perfCount;
  assign counts.eboxCount = eboxCount;
  assign counts.cacheCount = cacheCount;
  assign counts.intervalCount = intervalCount;

  mtrAxiSlave u_mtrAxiSlave (
    .MBOX_CLK (MBOX_CLK),
    .RESET    (RESET),
    .awaddr   (awaddr),
    .awvalid  (awvalid),
    .awready  (awready),
    .wdata    (wdata),
    .wstrb    (wstrb),
    .wvalid   (wvalid),
    .wready   (wready),
    .bresp    (bresp),
    .bvalid   (bvalid),
    .bready   (bready),
    .araddr   (araddr),
    .arvalid  (arvalid),
    .arready  (arready),
    .rdata    (rdata),
    .rresp    (rresp),
    .rvalid   (rvalid),
    .rready   (rready),
    .mtrCtl   (mtrCtlQ),
    .tmrCtl   (tmrCtlQ),
    .paCtl    (paCtlQ),
    .cmd      (cmd),
    .readSel  (readSel),
    .readData (readData)
  );

  mtrTimeBase #(
    .tickDivisor (tickDivisor)
  ) u_mtrTimeBase (
    .MBOX_CLK      (MBOX_CLK),
    .RESET         (RESET),
    .mtrCtl        (mtrCtlQ),
    .tmrCtl        (tmrCtlQ),
    .cmd           (cmd),
    .timeCount     (timeCount),
    .intervalCount (intervalCount),
    .flags         (flags),
    .irq           (irq)
  );

  mtrAccounting u_mtrAccounting (
    .MBOX_CLK   (MBOX_CLK),
    .RESET      (RESET),
    .mtrCtl     (mtrCtlQ),
    .paCtl      (paCtlQ),
    .cmd        (cmd),
    .cpu        (cpu),
    .perfCount  (perfCount),
    .eboxCount  (eboxCount),
    .cacheCount (cacheCount)
  );

  mtrReadback u_mtrReadback (
    .readSel  (readSel),
    .counts   (counts),
    .flags    (flags),
    .mtrCtl   (mtrCtlQ),
    .tmrCtl   (tmrCtlQ),
    .readData (readData)
  );

endmodule

// File: verif/mtrClockGen.sv
`timescale 1ns/1ps

module mtrClockGen #(
  parameter int halfPeriod = 10,
  parameter int resetCycles = 3
) (
  output logic MBOX_CLK,
  output logic RESET
);

  initial begin
    MBOX_CLK = 1'b0;
    forever #(halfPeriod) MBOX_CLK = ~MBOX_CLK;
  end

  initial begin
    RESET <= 1'b1;
    repeat (resetCycles) @(posedge MBOX_CLK);
    RESET <= 1'b0;
  end

endmodule

// File: verif/mtrTb.sv
`timescale 1ns/1ps

module mtrTb;
  import mtrPkg::*;

  localparam int tickDivisor = 4;
  localparam int seqLen = 40;
  localparam int waitLimit = 100;
  localparam logic [7:0] addrMtrCtl = 8'h00;
  localparam logic [7:0] addrTmrCtl = 8'h04;
  localparam logic [7:0] addrClear = 8'h08;
  localparam logic [7:0] addrPaCtl = 8'h0C;
  localparam logic [7:0] addrTime = 8'h10;
  localparam logic [7:0] addrPerf = 8'h14;
  localparam logic [7:0] addrEbox = 8'h18;
  localparam logic [7:0] addrCache = 8'h1C;
  localparam logic [7:0] addrInterval = 8'h20;
  localparam logic [7:0] addrStatus = 8'h24;
  localparam logic [7:0] addrUnmapped = 8'h30;
  localparam logic [1:0] respOkay = 2'b00;

  logic        MBOX_CLK;
  logic        RESET;
  logic [7:0]  awaddr;
  logic        awvalid;
  logic        awready;
  logic [31:0] wdata;
  logic [3:0]  wstrb;
  logic        wvalid;
  logic        wready;
  logic [1:0]  bresp;
  logic        bvalid;
  logic        bready;
  logic [7:0]  araddr;
  logic        arvalid;
  logic        arready;
  logic [31:0] rdata;
  logic [1:0]  rresp;
  logic        rvalid;
  logic        rready;
  cpuState     cpu;
  logic        irq;

  int passCount = 0;
  int failCount = 0;
  cpuState seqBuf [seqLen];
  string nameQ[$];
  logic [countWidth-1:0] expQ[$];
  logic [countWidth-1:0] actQ[$];

  mtrClockGen u_mtrClockGen (
    .MBOX_CLK (MBOX_CLK),
    .RESET    (RESET)
  );

  mtrTop #(
    .tickDivisor (tickDivisor)
  ) u_mtrTop (
    .MBOX_CLK (MBOX_CLK),
    .RESET    (RESET),
    .awaddr   (awaddr),
    .awvalid  (awvalid),
    .awready  (awready),
    .wdata    (wdata),
    .wstrb    (wstrb),
    .wvalid   (wvalid),
    .wready   (wready),
    .bresp    (bresp),
    .bvalid   (bvalid),
    .bready   (bready),
    .araddr   (araddr),
    .arvalid  (arvalid),
    .arready  (arready),
    .rdata    (rdata),
    .rresp    (rresp),
    .rvalid   (rvalid),
    .rready   (rready),
    .cpu      (cpu),
    .irq      (irq)
  );

  task automatic abortRun(input string what);
    $display("Timeout: %s", what);
    $display("RESULT: FAIL");
    $finish;
  endtask

  task automatic checkCount(input string name, input logic [countWidth-1:0] expected,
                            input logic [countWidth-1:0] actual);
    if (actual === expected) begin
      passCount++;
      $display("PASS %s: %0d", name, actual);
    end else begin
      failCount++;
      $display("FAIL %s: expected %0d, actual %0d", name, expected, actual);
    end
  endtask

  task automatic checkFlags(input string name, input tmrFlags expected, input tmrFlags actual);
    if (actual === expected) begin
      passCount++;
      $display("PASS %s: done/overflow %b", name, actual);
    end else begin
      failCount++;
      $display("FAIL %s: expected %b, actual %b", name, expected, actual);
    end
  endtask

  task automatic checkBit(input string name, input logic expected, input logic actual);
    if (actual === expected) begin
      passCount++;
      $display("PASS %s", name);
    end else begin
      failCount++;
      $display("FAIL %s: expected %b, actual %b", name, expected, actual);
    end
  endtask

  task automatic checkWord(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
    if (actual === expected) begin
      passCount++;
      $display("PASS %s: %h", name, actual);
    end else begin
      failCount++;
      $display("FAIL %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  // Response codes are checked on every transfer, reported only when wrong
  task automatic checkResp(input string name, input logic [1:0] expected,
                           input logic [1:0] actual);
    if (actual !== expected) begin
      failCount++;
      $display("FAIL %s: expected %b, actual %b", name, expected, actual);
    end
  endtask

  task automatic checkLess(input string name, input logic [countWidth-1:0] low,
                           input logic [countWidth-1:0] high);
    if (low < high) begin
      passCount++;
      $display("PASS %s: %0d < %0d", name, low, high);
    end else begin
      failCount++;
      $display("FAIL %s: expected below %0d, actual %0d", name, high, low);
    end
  endtask

  // Counter results are queued and compared by the process below
  task automatic expectCount(input string name, input logic [countWidth-1:0] expected,
                             input logic [countWidth-1:0] actual);
    nameQ.push_back(name);
    expQ.push_back(expected);
    actQ.push_back(actual);
  endtask

  always @(negedge MBOX_CLK) begin
    while (actQ.size() > 0) begin
      checkCount(nameQ.pop_front(), expQ.pop_front(), actQ.pop_front());
    end
  end

  task automatic axiWrite(input logic [7:0] addr, input logic [31:0] data, input int stall);
    int guard;
    logic heldOk;
    guard = 0;
    heldOk = 1'b1;
    @(posedge MBOX_CLK);
    awaddr <= addr;
    wdata <= data;
    wstrb <= 4'hF;
    awvalid <= 1'b1;
    wvalid <= 1'b1;
    @(negedge MBOX_CLK);
    while (!(awready && wready) && guard < waitLimit) begin
      @(negedge MBOX_CLK);
      guard++;
    end
    if (!(awready && wready)) abortRun("write address and data never accepted");
    @(posedge MBOX_CLK);
    awvalid <= 1'b0;
    wvalid <= 1'b0;
    guard = 0;
    @(negedge MBOX_CLK);
    while (!bvalid && guard < waitLimit) begin
      @(negedge MBOX_CLK);
      guard++;
    end
    if (!bvalid) abortRun("write response never arrived");
    checkResp("write response", respOkay, bresp);
    // BREADY stays low while the response must hold
    repeat (stall) begin
      @(negedge MBOX_CLK);
      if (!bvalid) heldOk = 1'b0;
    end
    @(posedge MBOX_CLK);
    bready <= 1'b1;
    @(posedge MBOX_CLK);
    bready <= 1'b0;
    if (stall > 0) checkBit("write response held under back-pressure", 1'b1, heldOk);
  endtask

  task automatic axiRead(input logic [7:0] addr, output logic [31:0] data, input int stall);
    int guard;
    logic heldOk;
    logic stableOk;
    guard = 0;
    heldOk = 1'b1;
    stableOk = 1'b1;
    @(posedge MBOX_CLK);
    araddr <= addr;
    arvalid <= 1'b1;
    @(negedge MBOX_CLK);
    while (!arready && guard < waitLimit) begin
      @(negedge MBOX_CLK);
      guard++;
    end
    if (!arready) abortRun("read address never accepted");
    @(posedge MBOX_CLK);
    arvalid <= 1'b0;
    guard = 0;
    @(negedge MBOX_CLK);
    while (!rvalid && guard < waitLimit) begin
      @(negedge MBOX_CLK);
      guard++;
    end
    if (!rvalid) abortRun("read data never arrived");
    data = rdata;
    checkResp("read response", respOkay, rresp);
    repeat (stall) begin
      @(negedge MBOX_CLK);
      if (!rvalid) heldOk = 1'b0;
      if (rdata !== data) stableOk = 1'b0;
    end
    @(posedge MBOX_CLK);
    rready <= 1'b1;
    @(posedge MBOX_CLK);
    rready <= 1'b0;
    if (stall > 0) begin
      checkBit("read valid held under back-pressure", 1'b1, heldOk);
      checkBit("read data unchanged under back-pressure", 1'b1, stableOk);
    end
  endtask

  function automatic tmrFlags flagsOf(input logic [31:0] word);
    tmrFlags f;
    f.done = word[13];
    f.overflow = word[14];
    return f;
  endfunction

  // Expected counter deltas over one applied sequence
  function automatic mtrCounts expectedCounts(input cpuState seq [seqLen], input mtrCtl ctl,
                                              input paCtl pa);
    mtrCounts sums;
    logic acct;
    logic perfHit;
    sums = '0;
    for (int i = 0; i < seqLen; i++) begin
      acct = ctl.acctOn && (!seq[i].piActive || ctl.piAcctEn) &&
             (seq[i].userMode || ctl.execAcctEn);
      perfHit = pa.eventMode ? seq[i].mboxXfer : seq[i].eboxWait;
      if (pa.userOnly && !seq[i].userMode) perfHit = 1'b0;
      if (acct && seq[i].mboxXfer) sums.cacheCount = sums.cacheCount + 1'b1;
      if (acct && !seq[i].eboxWait) sums.eboxCount = sums.eboxCount + 1'b1;
      if (perfHit) sums.perfCount = sums.perfCount + 1'b1;
    end
    return sums;
  endfunction

  task automatic fillSeq();
    for (int i = 0; i < seqLen; i++) begin
      seqBuf[i] = cpuState'(4'($urandom));
    end
  endtask

  task automatic applySeq(input cpuState rest);
    for (int i = 0; i < seqLen; i++) begin
      @(posedge MBOX_CLK);
      cpu <= seqBuf[i];
    end
    @(posedge MBOX_CLK);
    cpu <= rest;
  endtask

  task automatic resetValues();
    logic [31:0] word;
    axiRead(addrTime, word, 0);
    expectCount("reset time", '0, word[countWidth-1:0]);
    axiRead(addrPerf, word, 0);
    expectCount("reset perf", '0, word[countWidth-1:0]);
    axiRead(addrEbox, word, 0);
    expectCount("reset ebox", '0, word[countWidth-1:0]);
    axiRead(addrCache, word, 0);
    expectCount("reset cache", '0, word[countWidth-1:0]);
    axiRead(addrInterval, word, 0);
    expectCount("reset interval", '0, word[countWidth-1:0]);
    axiRead(addrStatus, word, 0);
    checkFlags("reset flags", tmrFlags'(2'b00), flagsOf(word));
    checkBit("reset irq", 1'b0, irq);
  endtask

  task automatic cacheEboxAccounting();
    mtrCtl ctl;
    paCtl pa;
    mtrCounts sums;
    logic [31:0] word;
    cpuState waitOnly;
    pa = '0;
    waitOnly = '0;
    waitOnly.eboxWait = 1'b1;
    for (int k = 0; k < 4; k++) begin
      ctl.acctOn = 1'b1;
      ctl.piAcctEn = k[1];
      ctl.execAcctEn = k[0];
      ctl.timeOn = 1'b0;
      // Wait-only input counts neither ebox nor cache
      @(posedge MBOX_CLK);
      cpu <= waitOnly;
      axiWrite(addrMtrCtl, {28'b0, ctl}, 0);
      axiWrite(addrClear, 32'h0000_000E, 0);
      fillSeq();
      applySeq(waitOnly);
      axiWrite(addrMtrCtl, 32'h0, 0);
      @(posedge MBOX_CLK);
      cpu <= '0;
      repeat (4) @(posedge MBOX_CLK);
      sums = expectedCounts(seqBuf, ctl, pa);
      axiRead(addrEbox, word, 0);
      expectCount($sformatf("ebox, pi %0d exec %0d", k[1], k[0]), sums.eboxCount,
                  word[countWidth-1:0]);
      axiRead(addrCache, word, 0);
      expectCount($sformatf("cache, pi %0d exec %0d", k[1], k[0]), sums.cacheCount,
                  word[countWidth-1:0]);
    end
  endtask

  task automatic perfCounting();
    paCtl pa;
    mtrCounts sums;
    logic [31:0] word;
    for (int k = 0; k < 4; k++) begin
      pa.userOnly = k[1];
      pa.eventMode = k[0];
      axiWrite(addrPaCtl, {30'b0, pa}, 0);
      axiWrite(addrClear, 32'h0000_0002, 0);
      fillSeq();
      applySeq('0);
      repeat (4) @(posedge MBOX_CLK);
      sums = expectedCounts(seqBuf, mtrCtl'(4'b0), pa);
      axiRead(addrPerf, word, 0);
      expectCount($sformatf("perf, userOnly %0d event %0d", k[1], k[0]), sums.perfCount,
                  word[countWidth-1:0]);
    end
    axiWrite(addrClear, 32'h0000_0002, 0);
    axiRead(addrPerf, word, 0);
    expectCount("perf cleared", '0, word[countWidth-1:0]);
  endtask

  task automatic timeBaseRuns();
    logic [31:0] first;
    logic [31:0] second;
    axiWrite(addrMtrCtl, 32'h0000_0001, 0);
    axiRead(addrTime, first, 0);
    repeat (12) @(posedge MBOX_CLK);
    axiRead(addrTime, second, 0);
    checkLess("time advances", first[countWidth-1:0], second[countWidth-1:0]);
    axiWrite(addrMtrCtl, 32'h0, 0);
    repeat (8) @(posedge MBOX_CLK);
    axiRead(addrTime, first, 0);
    repeat (12) @(posedge MBOX_CLK);
    axiRead(addrTime, second, 0);
    expectCount("time holds when off", first[countWidth-1:0], second[countWidth-1:0]);
  endtask

  task automatic intervalTimer();
    int guard;
    logic [31:0] word;
    // Period 5, timer on, interval counter reset
    axiWrite(addrTmrCtl, 32'h0000_3005, 0);
    guard = 0;
    @(negedge MBOX_CLK);
    while (!irq && guard < waitLimit) begin
      @(negedge MBOX_CLK);
      guard++;
    end
    if (!irq) abortRun("interval interrupt never raised");
    axiRead(addrStatus, word, 0);
    checkFlags("done without overflow", tmrFlags'(2'b10), flagsOf(word));
    axiRead(addrInterval, word, 0);
    checkLess("interval below period", word[countWidth-1:0], 17'd5);
    guard = 0;
    axiRead(addrStatus, word, 0);
    while (!word[14] && guard < waitLimit) begin
      axiRead(addrStatus, word, 0);
      guard++;
    end
    if (!word[14]) begin
      abortRun("interval overflow never set");
    end else begin
      checkFlags("done with overflow", tmrFlags'(2'b11), flagsOf(word));
    end
    axiWrite(addrTmrCtl, 32'h0000_2005, 0);
    axiWrite(addrClear, 32'h0000_0020, 0);
    @(negedge MBOX_CLK);
    checkBit("irq dropped by flag clear", 1'b0, irq);
    axiRead(addrStatus, word, 0);
    checkFlags("flags cleared", tmrFlags'(2'b00), flagsOf(word));
  endtask

  task automatic busBackPressure();
    logic [31:0] word;
    axiWrite(addrMtrCtl, 32'h0000_0001, 3 + int'($urandom % 8));
    // Time keeps running while the read response is held
    axiRead(addrTime, word, 6 + int'($urandom % 10));
    axiRead(addrUnmapped, word, 0);
    checkWord("unmapped read", 32'h0, word);
    axiWrite(addrUnmapped, 32'hFFFF_FFFF, 0);
    axiRead(addrStatus, word, 0);
    // timeOn in bit 15, period 5 with the timer off, flags clear
    checkWord("unmapped write ignored", 32'h0000_8005, word);
  endtask

  initial begin
    int guard;
    void'($urandom(42));
    awaddr <= '0;
    awvalid <= 1'b0;
    wdata <= '0;
    wstrb <= '0;
    wvalid <= 1'b0;
    bready <= 1'b0;
    araddr <= '0;
    arvalid <= 1'b0;
    rready <= 1'b0;
    cpu <= '0;
    guard = 0;
    @(negedge MBOX_CLK);
    while (RESET && guard < waitLimit) begin
      @(negedge MBOX_CLK);
      guard++;
    end
    if (RESET) abortRun("reset never released");

    resetValues();
    cacheEboxAccounting();
    perfCounting();
    timeBaseRuns();
    intervalTimer();
    busBackPressure();

    guard = 0;
    while (actQ.size() > 0 && guard < waitLimit) begin
      @(negedge MBOX_CLK);
      guard++;
    end
    if (actQ.size() > 0) begin
      abortRun("queued counter compares never drained");
    end else begin
      $display("Checks done: %0d passed, %0d failed", passCount, failCount);
      if (failCount == 0) begin
        $display("RESULT: PASS");
      end else begin
        $display("RESULT: FAIL");
      end
      $finish;
    end
  end

endmodule

// File: mtrTop.f
source/mtrPkg.sv
source/mtrAxiSlave.sv
source/mtrTimeBase.sv
source/mtrAccounting.sv
source/mtrReadback.sv
source/mtrTop.sv
verif/mtrClockGen.sv
verif/mtrTb.sv

// File: runSim.sh
#!/bin/sh
# Builds the meter testbench with Verilator and runs it into sim.log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module mtrTb -f mtrTop.f --Mdir obj_dir -o mtrSim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/mtrSim > sim.log 2>&1
runStatus=$?
cat sim.log
if [ $runStatus -ne 0 ]; then
  echo "Simulation exited with status $runStatus"
  exit 1
fi

if grep -q "RESULT: FAIL" sim.log; then
  exit 1
fi
exit 0
